//--- design/fixed_div_macros.svh
`ifndef FIXED_DIV_MACROS_SVH
`define FIXED_DIV_MACROS_SVH

// Width of one Q16.16 value.
`define FIXED_W 32

// Fraction bits of the Q16.16 format.
`define FIXED_FRAC 16

// Widened dividend and raw quotient.
// Holds a Q16.16 value shifted up by the fraction bits.
`define WIDE_W 48

// One restoring step per quotient bit.
`define DIV_ITER `WIDE_W

`endif

//--- design/fixed_pkg.sv
`default_nettype none

`include "fixed_div_macros.svh"

package fixed_pkg;

    // Signed Q16.16 value.
    typedef logic signed [`FIXED_W-1:0] fixed_t;

    // Widened dividend and raw quotient.
    // The dividend is the Q16.16 value scaled by 2^16.
    typedef logic signed [`WIDE_W-1:0] wide_t;

    // Counts the divider steps.
    typedef logic [$clog2(`DIV_ITER)-1:0] iter_t;

    // Divider control states.
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

//--- design/div_operand_fork.sv
`timescale 1ns/1ps
`default_nettype none

`include "fixed_div_macros.svh"

module div_operand_fork (
    input  logic             aclk,
    input  logic             arst_n,

    // Operand pair from the input stream.
    input  logic             s_axis_tvalid,
    output logic             s_axis_tready,
    input  fixed_pkg::fixed_t s_axis_a,
    input  fixed_pkg::fixed_t s_axis_b,

    // Widened dividend towards the divider.
    output logic             dividend_tvalid,
    input  logic             dividend_tready,
    output fixed_pkg::wide_t dividend_tdata,

    // Raw divisor towards the divider.
    output logic             divisor_tvalid,
    input  logic             divisor_tready,
    output fixed_pkg::fixed_t divisor_tdata
);

    // One pending flag per fork branch.
    logic pend_dividend;
    logic pend_divisor;

    // Holding register for the current pair.
    fixed_pkg::wide_t  dividend_q;
    fixed_pkg::fixed_t divisor_q;

    logic accept;

    // Free only when both branches have been taken.
    assign s_axis_tready = ~(pend_dividend | pend_divisor);
    assign accept        = s_axis_tvalid & s_axis_tready;

    // Control flags.
    // A new pair can only land while both flags are clear.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pend_dividend <= 1'b0;
            pend_divisor  <= 1'b0;
        end else if (accept) begin
            pend_dividend <= 1'b1;
            pend_divisor  <= 1'b1;
        end else begin
            // Each branch retires on its own transfer.
            if (dividend_tvalid && dividend_tready) begin
                pend_dividend <= 1'b0;
            end
            if (divisor_tvalid && divisor_tready) begin
                pend_divisor <= 1'b0;
            end
        end
    end

    // Payload capture.
    // Sign extend a to the wide format, then scale by 2^16.
    always_ff @(posedge aclk) begin
        if (accept) begin
            dividend_q <= fixed_pkg::wide_t'(s_axis_a) <<< `FIXED_FRAC;
            divisor_q  <= s_axis_b;
        end
    end

    assign dividend_tvalid = pend_dividend;
    assign dividend_tdata  = dividend_q;
    assign divisor_tvalid  = pend_divisor;
    assign divisor_tdata   = divisor_q;

endmodule

`default_nettype wire

//--- design/divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "fixed_div_macros.svh"

module divider (
    input  logic              aclk,
    input  logic              arst_n,

    // Dividend operand stream.
    input  logic              dividend_tvalid,
    output logic              dividend_tready,
    input  fixed_pkg::wide_t  dividend_tdata,

    // Divisor operand stream.
    input  logic              divisor_tvalid,
    output logic              divisor_tready,
    input  fixed_pkg::fixed_t divisor_tdata,

    // Quotient result stream.
    output logic              quot_tvalid,
    input  logic              quot_tready,
    output fixed_pkg::wide_t  quot_tdata,
    output logic              quot_div_zero
);

    fixed_pkg::div_state_t state;
    fixed_pkg::iter_t      iter_cnt;

    // Partial remainder, always below the divisor magnitude.
    logic [`FIXED_W-1:0] rem_q;
    // Dividend bits shift out on top, quotient bits enter below.
    logic [`WIDE_W-1:0]  quo_q;
    logic [`FIXED_W-1:0] dmag_q;

    // Operand signs and zero divisor flag, kept for the done state.
    logic a_neg_q;
    logic q_neg_q;
    logic div_zero_q;

    logic             out_valid;
    fixed_pkg::wide_t out_data;

    logic                accept;
    logic                a_neg;
    logic                b_neg;
    logic [`WIDE_W-1:0]  a_mag;
    logic [`FIXED_W-1:0] b_mag;

    // One restoring step.
    logic [`FIXED_W:0]   rem_shift;
    logic [`FIXED_W:0]   rem_diff;
    logic                take;
    fixed_pkg::wide_t    result;

    // Both operands move together, and only while idle.
    assign dividend_tready = (state == fixed_pkg::DIV_IDLE);
    assign divisor_tready  = (state == fixed_pkg::DIV_IDLE);
    assign accept = (state == fixed_pkg::DIV_IDLE) & dividend_tvalid & divisor_tvalid;

    // Operand magnitudes.
    assign a_neg = dividend_tdata[`WIDE_W-1];
    assign b_neg = divisor_tdata[`FIXED_W-1];
    assign a_mag = a_neg ? -dividend_tdata : dividend_tdata;
    assign b_mag = b_neg ? -divisor_tdata : divisor_tdata;

    // Bring down the next dividend bit and try the subtraction.
    assign rem_shift = {rem_q, quo_q[`WIDE_W-1]};
    assign rem_diff  = rem_shift - {1'b0, dmag_q};
    assign take      = (rem_shift >= {1'b0, dmag_q});

    // Signed quotient.
    always_comb begin
        if (div_zero_q) begin
            // Limit of the dividend sign; zero counts as positive.
            result = a_neg_q ? fixed_pkg::wide_t'({1'b1, {(`WIDE_W-1){1'b0}}})
                             : fixed_pkg::wide_t'({1'b0, {(`WIDE_W-1){1'b1}}});
        end else if (q_neg_q) begin
            result = fixed_pkg::wide_t'(-quo_q);
        end else if (quo_q[`WIDE_W-1]) begin
            // Only -32768.0 over -2^-16 gets here.
            result = fixed_pkg::wide_t'({1'b0, {(`WIDE_W-1){1'b1}}});
        end else begin
            result = fixed_pkg::wide_t'(quo_q);
        end
    end

    // Control FSM.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= fixed_pkg::DIV_IDLE;
            iter_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                fixed_pkg::DIV_IDLE: begin
                    if (accept) begin
                        state    <= fixed_pkg::DIV_RUN;
                        iter_cnt <= '0;
                    end
                end
                fixed_pkg::DIV_RUN: begin
                    // Fixed step count, even for a zero divisor.
                    if (iter_cnt == fixed_pkg::iter_t'(`DIV_ITER - 1)) begin
                        state <= fixed_pkg::DIV_DONE;
                    end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                fixed_pkg::DIV_DONE: begin
                    // Sign cycle first, then hold until taken.
                    if (!out_valid) begin
                        out_valid <= 1'b1;
                    end else if (quot_tready) begin
                        out_valid <= 1'b0;
                        state     <= fixed_pkg::DIV_IDLE;
                    end
                end
                default: begin
                    state <= fixed_pkg::DIV_IDLE;
                end
            endcase
        end
    end

    // Datapath.
    always_ff @(posedge aclk) begin
        if (accept) begin
            rem_q      <= '0;
            quo_q      <= a_mag;
            dmag_q     <= b_mag;
            a_neg_q    <= a_neg;
            q_neg_q    <= a_neg ^ b_neg;
            div_zero_q <= (divisor_tdata == '0);
        end else if (state == fixed_pkg::DIV_RUN) begin
            rem_q <= take ? rem_diff[`FIXED_W-1:0] : rem_shift[`FIXED_W-1:0];
            quo_q <= {quo_q[`WIDE_W-2:0], take};
        end
        if (state == fixed_pkg::DIV_DONE && !out_valid) begin
            out_data <= result;
        end
    end

    assign quot_tvalid   = out_valid;
    assign quot_tdata    = out_data;
    assign quot_div_zero = div_zero_q;

endmodule

`default_nettype wire

//--- design/quotient_saturate.sv
`timescale 1ns/1ps
`default_nettype none

`include "fixed_div_macros.svh"

module quotient_saturate (
    input  logic              aclk,
    input  logic              arst_n,

    // Raw quotient from the divider.
    input  logic              quot_tvalid,
    output logic              quot_tready,
    input  fixed_pkg::wide_t  quot_tdata,
    input  logic              quot_div_zero,

    // Q16.16 result stream.
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output fixed_pkg::fixed_t m_axis_tdata
);

    logic              fits;
    fixed_pkg::fixed_t sat;
    fixed_pkg::fixed_t limit;
    logic              slot_valid;
    fixed_pkg::fixed_t slot_data;

    // In range when the upper bits all copy the sign bit.
    assign fits  = (quot_tdata[`WIDE_W-1:`FIXED_W-1] == {(`WIDE_W-`FIXED_W+1){quot_tdata[`WIDE_W-1]}});
    assign limit = quot_tdata[`WIDE_W-1] ? fixed_pkg::fixed_t'({1'b1, {(`FIXED_W-1){1'b0}}})
                                         : fixed_pkg::fixed_t'({1'b0, {(`FIXED_W-1){1'b1}}});

    // Zero divisor always takes the limit of the carried sign.
    assign sat = (fits && !quot_div_zero) ? quot_tdata[`FIXED_W-1:0] : limit;

    // Empty slot, or one draining on this edge.
    assign quot_tready = ~slot_valid | m_axis_tready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= 1'b0;
        end else if (quot_tready) begin
            slot_valid <= quot_tvalid;
        end
    end

    // Result register.
    always_ff @(posedge aclk) begin
        if (quot_tvalid && quot_tready) begin
            slot_data <= sat;
        end
    end

    assign m_axis_tvalid = slot_valid;
    assign m_axis_tdata  = slot_data;

endmodule

`default_nettype wire

//--- design/fixed_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_div_top (
    input  logic              aclk,
    input  logic              arst_n,

    // Operand pairs, a over b.
    input  logic              s_axis_tvalid,
    output logic              s_axis_tready,
    input  fixed_pkg::fixed_t s_axis_a,
    input  fixed_pkg::fixed_t s_axis_b,

    // Saturated Q16.16 quotients.
    output logic              m_axis_tvalid,
    input  logic              m_axis_tready,
    output fixed_pkg::fixed_t m_axis_tdata
);

    // Fork to divider.
    logic              dividend_tvalid;
    logic              dividend_tready;
    fixed_pkg::wide_t  dividend_tdata;
    logic              divisor_tvalid;
    logic              divisor_tready;
    fixed_pkg::fixed_t divisor_tdata;

    // Divider to saturation.
    logic              quot_tvalid;
    logic              quot_tready;
    fixed_pkg::wide_t  quot_tdata;
    logic              quot_div_zero;

    div_operand_fork div_operand_fork_i (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tready   (s_axis_tready),
        .s_axis_a        (s_axis_a),
        .s_axis_b        (s_axis_b),
        .dividend_tvalid (dividend_tvalid),
        .dividend_tready (dividend_tready),
        .dividend_tdata  (dividend_tdata),
        .divisor_tvalid  (divisor_tvalid),
        .divisor_tready  (divisor_tready),
        .divisor_tdata   (divisor_tdata)
    );

    // Single division in flight.
    divider divider_i (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .dividend_tvalid (dividend_tvalid),
        .dividend_tready (dividend_tready),
        .dividend_tdata  (dividend_tdata),
        .divisor_tvalid  (divisor_tvalid),
        .divisor_tready  (divisor_tready),
        .divisor_tdata   (divisor_tdata),
        .quot_tvalid     (quot_tvalid),
        .quot_tready     (quot_tready),
        .quot_tdata      (quot_tdata),
        .quot_div_zero   (quot_div_zero)
    );

    quotient_saturate quotient_saturate_i (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .quot_tvalid     (quot_tvalid),
        .quot_tready     (quot_tready),
        .quot_tdata      (quot_tdata),
        .quot_div_zero   (quot_div_zero),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tready   (m_axis_tready),
        .m_axis_tdata    (m_axis_tdata)
    );

endmodule

`default_nettype wire

//--- test/fixed_div_props.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_div_props (
    input logic              aclk,
    input logic              arst_n,
    input logic              s_axis_tvalid,
    input logic              s_axis_tready,
    input fixed_pkg::fixed_t s_axis_a,
    input fixed_pkg::fixed_t s_axis_b,
    input logic              dividend_tvalid,
    input logic              dividend_tready,
    input fixed_pkg::wide_t  dividend_tdata,
    input logic              divisor_tvalid,
    input logic              divisor_tready,
    input fixed_pkg::fixed_t divisor_tdata,
    input logic              quot_tvalid,
    input logic              quot_tready,
    input fixed_pkg::wide_t  quot_tdata,
    input logic              quot_div_zero,
    input logic              m_axis_tvalid,
    input logic              m_axis_tready,
    input fixed_pkg::fixed_t m_axis_tdata
);

    // Number of assertion failures so far.
    int assert_fail_count = 0;

    // Input pair holds until the fork takes it.
    s_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        s_axis_tvalid && !s_axis_tready |=>
            s_axis_tvalid && $stable(s_axis_a) && $stable(s_axis_b))
        else begin
            assert_fail_count++;
            $error("s_axis pair changed before its transfer");
        end

    dividend_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        dividend_tvalid && !dividend_tready |=> dividend_tvalid && $stable(dividend_tdata))
        else begin
            assert_fail_count++;
            $error("dividend stream changed before its transfer");
        end

    divisor_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        divisor_tvalid && !divisor_tready |=> divisor_tvalid && $stable(divisor_tdata))
        else begin
            assert_fail_count++;
            $error("divisor stream changed before its transfer");
        end

    // Zero divisor flag travels with the quotient.
    quot_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        quot_tvalid && !quot_tready |=>
            quot_tvalid && $stable(quot_tdata) && $stable(quot_div_zero))
        else begin
            assert_fail_count++;
            $error("quotient stream changed before its transfer");
        end

    m_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
        else begin
            assert_fail_count++;
            $error("m_axis result changed before its transfer");
        end

    // No new operands while a quotient waits.
    busy_no_ready: assert property (@(posedge aclk) disable iff (!arst_n)
        quot_tvalid |-> !dividend_tready && !divisor_tready)
        else begin
            assert_fail_count++;
            $error("divider ready while a quotient is pending");
        end

    reset_quiet: assert property (@(posedge aclk) $rose(arst_n) |-> !m_axis_tvalid)
        else begin
            assert_fail_count++;
            $error("m_axis_tvalid high right after reset release");
        end

endmodule

bind fixed_div_top fixed_div_props fixed_div_props_i (.*);

`default_nettype wire

//--- test/tb_fixed_div.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fixed_div;

    // Run length.
    localparam int N_DIRECTED     = 13;
    localparam int N_RANDOM       = 200;
    localparam int N_PAIRS        = 1 + N_DIRECTED + N_RANDOM;
    localparam int STALL_BUDGET   = 500;
    localparam int TIMEOUT_CYCLES = N_PAIRS * 60 + STALL_BUDGET;

    // Rising edges from input accept to output valid.
    localparam int EXP_LATENCY = 51;

    // Signed 32-bit limits of Q16.16.
    localparam logic [31:0] FIX_MAX = 32'h7fff_ffff;
    localparam logic [31:0] FIX_MIN = 32'h8000_0000;

    logic              aclk;
    logic              arst_n;
    logic              s_axis_tvalid;
    logic              s_axis_tready;
    fixed_pkg::fixed_t s_axis_a;
    fixed_pkg::fixed_t s_axis_b;
    logic              m_axis_tvalid;
    logic              m_axis_tready;
    fixed_pkg::fixed_t m_axis_tdata;

    logic [31:0]       lfsr_q;
    logic              stall_en;
    int                cyc;
    int                result_count;
    int                last_accept_edge;
    fixed_pkg::fixed_t exp_now;

    // Expected results in input order.
    fixed_pkg::fixed_t exp_q[$];

    fixed_div_top fixed_div_top_i (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_a      (s_axis_a),
        .s_axis_b      (s_axis_b),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata)
    );

    // 8 ns clock.
    always #4 aclk = ~aclk;

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // Expected quotient: (a * 65536) / b, truncated and clamped.
    function automatic fixed_pkg::fixed_t ref_fixed_div(input fixed_pkg::fixed_t a,
                                                        input fixed_pkg::fixed_t b);
        longint num;
        longint q;
        if (b == 0) begin
            // Zero divisor picks the limit of the dividend sign.
            return (a < 0) ? FIX_MIN : FIX_MAX;
        end
        num = longint'(a) * 65536;
        q   = num / longint'(b);
        if (q > longint'(32'sh7fff_ffff)) begin
            return FIX_MAX;
        end
        if (q < longint'(32'sh8000_0000)) begin
            return FIX_MIN;
        end
        return fixed_pkg::fixed_t'(q);
    endfunction

    // Stops the run on the first mismatch.
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Next falling edge, with a fresh ready value.
    task automatic tick();
        @(negedge aclk);
        if (stall_en) begin
            // Ready low one cycle in four.
            m_axis_tready = (take_bits(2) != 0);
        end else begin
            m_axis_tready = 1'b1;
        end
    endtask

    // Offer one pair and hold it until the fork takes it.
    task automatic send_pair(input fixed_pkg::fixed_t a, input fixed_pkg::fixed_t b,
                             input logic gaps);
        logic [31:0] gap;
        gap = gaps ? take_bits(2) : 32'd0;
        repeat (gap) tick();
        s_axis_tvalid = 1'b1;
        s_axis_a      = a;
        s_axis_b      = b;
        // Ready is a register output, so it is settled here.
        while (!s_axis_tready) begin
            tick();
        end
        exp_q.push_back(ref_fixed_div(a, b));
        last_accept_edge = cyc + 1;
        tick();
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_directed();
        send_pair(32'h0006_0000, 32'h0002_0000, 1'b0);  // 6.0 / 2.0
        send_pair(32'hfff8_8000, 32'h0002_8000, 1'b0);  // -7.5 / 2.5
        send_pair(32'h0001_0000, 32'hfffc_0000, 1'b0);  // 1.0 / -4.0
        send_pair(32'hfffd_0000, 32'hffff_8000, 1'b0);  // -3.0 / -0.5
        send_pair(32'hffff_0000, 32'h0003_0000, 1'b0);  // -1.0 / 3.0, truncates up.
        // Large dividend over small divisor.
        send_pair(32'h7530_0000, 32'h0000_4000, 1'b0);  // 30000.0 / 0.25
        send_pair(32'h8ad0_0000, 32'h0000_4000, 1'b0);  // -30000.0 / 0.25
        send_pair(32'h4e20_0000, 32'hffff_ffbf, 1'b0);  // 20000.0 / -0.001
        send_pair(32'h8000_0000, 32'hffff_ffff, 1'b0);  // Most negative over -2^-16.
        // Zero divisor, each dividend sign.
        send_pair(32'h0001_2345, 32'h0000_0000, 1'b0);
        send_pair(32'h0000_0000, 32'h0000_0000, 1'b0);
        send_pair(32'hffff_0000, 32'h0000_0000, 1'b0);
        send_pair(32'h0002_0000, 32'h0001_8000, 1'b0);  // 2.0 / 1.5
    endtask

    // Random operands with random magnitudes.
    task automatic run_random();
        fixed_pkg::fixed_t a;
        fixed_pkg::fixed_t b;
        logic [31:0]       a_sh;
        logic [31:0]       b_sh;
        for (int i = 0; i < N_RANDOM; i++) begin
            a    = take_bits(32);
            a_sh = take_bits(4);
            b    = take_bits(32);
            b_sh = take_bits(5);
            // Wide shifts of b also give 0 and -1 divisors.
            send_pair(a >>> a_sh, b >>> b_sh, 1'b1);
        end
    endtask

    // Cycle counter and timeout.
    always @(posedge aclk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cyc, result_count, N_PAIRS);
            $display("STATUS: FAIL");
            $fatal(1, "run did not finish in time");
        end
    end

    // A failed stream protocol assertion ends the run too.
    always @(posedge aclk) begin
        if (fixed_div_top_i.fixed_div_props_i.assert_fail_count != 0) begin
            $display("A stream protocol assertion failed before %0t", $time);
            $display("STATUS: FAIL");
            $fatal(1, "protocol assertion failure");
        end
    end

    // Compare every output transfer with the oldest expected value.
    always @(posedge aclk) begin
        if (arst_n && m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer at %0t with no result outstanding", $time);
                $display("STATUS: FAIL");
                $fatal(1, "extra output transfer");
            end else begin
                exp_now = exp_q.pop_front();
                result_count++;
                check_value("m_axis_tdata", m_axis_tdata, exp_now);
            end
        end
    end

    initial begin
        aclk             = 1'b0;
        arst_n           = 1'b0;
        s_axis_tvalid    = 1'b0;
        s_axis_a         = '0;
        s_axis_b         = '0;
        m_axis_tready    = 1'b1;
        lfsr_q           = 32'h7438_5a8f;
        stall_en         = 1'b0;
        cyc              = 0;
        result_count     = 0;
        last_accept_edge = 0;

        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
        tick();

        // Latency of one pair through an idle pipeline.
        send_pair(32'h0001_0000, 32'h0003_0000, 1'b0);
        while (!m_axis_tvalid) begin
            tick();
        end
        check_value("m_axis_tvalid latency", cyc - last_accept_edge, EXP_LATENCY);

        send_directed();

        // Random traffic with gaps and stalls.
        stall_en = 1'b1;
        run_random();
        stall_en = 1'b0;

        // Drain, then watch for stray outputs.
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (60) tick();

        if (fixed_div_top_i.fixed_div_props_i.assert_fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Stream protocol assertions failed %0d times",
                     fixed_div_top_i.fixed_div_props_i.assert_fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "protocol assertion failure");
        end
    end

endmodule

`default_nettype wire

//--- fixed_div.f
+incdir+design
design/fixed_pkg.sv
design/div_operand_fork.sv
design/divider.sv
design/quotient_saturate.sv
design/fixed_div_top.sv
test/fixed_div_props.sv
test/tb_fixed_div.sv
